//--- verilog/cpu_params.sv
package cpu_params;

    localparam int XLEN      = 32;
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;
    localparam int AREG_W    = 5;
    localparam int PREG_W    = 6;
    localparam int ROB_DEPTH = 16;
    localparam int ROB_IDX_W = 4;
    localparam int RS_DEPTH  = 8;
    localparam int RS_IDX_W  = 3;
    localparam int FL_DEPTH  = PHYS_REGS - ARCH_REGS;
    localparam int FL_IDX_W  = 5;

    // Major opcodes of the supported integer instructions.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } rv_opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef struct packed {
        alu_op_e           op;
        logic [AREG_W-1:0] rd;
        logic [AREG_W-1:0] rs1;
        logic [AREG_W-1:0] rs2;
        logic [XLEN-1:0]   imm;
        logic              use_imm;
    } decoded_t;

    typedef struct packed {
        logic [AREG_W-1:0] rs1;
        logic [AREG_W-1:0] rs2;
        logic [AREG_W-1:0] rd;
        logic              we;
    } rename_req_t;

    typedef struct packed {
        logic [PREG_W-1:0] ps1;
        logic [PREG_W-1:0] ps2;
        logic              rdy1;
        logic              rdy2;
        logic [PREG_W-1:0] old_pd;
    } rename_rsp_t;

    typedef struct packed {
        alu_op_e              op;
        logic [PREG_W-1:0]    ps1;
        logic [PREG_W-1:0]    ps2;
        logic                 rdy1;
        logic                 rdy2;
        logic [PREG_W-1:0]    pd;
        logic                 has_dest;
        logic [XLEN-1:0]      imm;
        logic                 use_imm;
        logic [ROB_IDX_W-1:0] rob_idx;
    } rs_entry_t;

    typedef struct packed {
        alu_op_e              op;
        logic [PREG_W-1:0]    ps1;
        logic [PREG_W-1:0]    ps2;
        logic [PREG_W-1:0]    pd;
        logic                 has_dest;
        logic [XLEN-1:0]      imm;
        logic                 use_imm;
        logic [ROB_IDX_W-1:0] rob_idx;
    } issue_t;

    typedef struct packed {
        logic                 valid;
        logic [PREG_W-1:0]    pd;
        logic                 has_dest;
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [XLEN-1:0]      data;
    } cdb_t;

    // Written into the ROB at dispatch.
    typedef struct packed {
        logic [AREG_W-1:0] rd;
        logic [PREG_W-1:0] pd;
        logic              has_dest;
    } rob_alloc_t;

    typedef struct packed {
        logic              valid;
        logic [AREG_W-1:0] rd;
        logic [PREG_W-1:0] pd;
        logic              has_dest;
    } retire_t;

    typedef struct packed {
        logic [AREG_W-1:0] rd;
        logic [XLEN-1:0]   data;
    } commit_t;

endpackage

//--- verilog/id_stage.sv
module id_stage
import cpu_params::*;
(
    input  logic                 inst_valid_i,
    input  logic [31:0]          inst_i,
    output logic                 inst_pop_o,
    input  logic                 rob_full_i,
    input  logic                 rs_full_i,
    input  logic                 fl_empty_i,
    output rename_req_t          ren_req_o,
    input  rename_rsp_t          ren_rsp_i,
    output logic                 fl_pop_o,
    input  logic [PREG_W-1:0]    fl_tag_i,
    output logic                 rob_alloc_o,
    output rob_alloc_t           rob_entry_o,
    input  logic [ROB_IDX_W-1:0] rob_idx_i,
    output logic                 rs_write_o,
    output rs_entry_t            rs_entry_o
);

    decoded_t   dec;
    logic       supported;
    logic       has_dest;
    logic       stall;
    logic       dispatch;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    always_comb begin
        dec.op      = ALU_ADD;
        dec.rd      = inst_i[11:7];
        dec.rs1     = inst_i[19:15];
        dec.rs2     = inst_i[24:20];
        dec.imm     = {{20{inst_i[31]}}, inst_i[31:20]};
        dec.use_imm = 1'b0;
        supported   = 1'b1;
        case (inst_i[6:0])
            OPC_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: dec.op = ALU_ADD;
                    10'b0100000_000: dec.op = ALU_SUB;
                    10'b0000000_111: dec.op = ALU_AND;
                    10'b0000000_110: dec.op = ALU_OR;
                    10'b0000000_100: dec.op = ALU_XOR;
                    default:         supported = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                // rs2 points at x0 so the operand is always ready.
                dec.use_imm = 1'b1;
                dec.rs2     = '0;
                case (funct3)
                    3'b000:  dec.op = ALU_ADD;
                    3'b111:  dec.op = ALU_AND;
                    3'b110:  dec.op = ALU_OR;
                    3'b100:  dec.op = ALU_XOR;
                    default: supported = 1'b0;
                endcase
            end
            default: supported = 1'b0;
        endcase
    end

    assign has_dest = dec.rd != '0;
    assign stall    = rob_full_i | rs_full_i | (has_dest & fl_empty_i);
    assign dispatch = inst_valid_i & supported & ~stall;

    // Unsupported words leave the queue without a stall.
    assign inst_pop_o = inst_valid_i & (~supported | ~stall);

    always_comb begin
        ren_req_o.rs1 = dec.rs1;
        ren_req_o.rs2 = dec.rs2;
        ren_req_o.rd  = dec.rd;
        ren_req_o.we  = dispatch & has_dest;
    end

    assign fl_pop_o    = dispatch & has_dest;
    assign rob_alloc_o = dispatch;
    assign rs_write_o  = dispatch;

    always_comb begin
        rob_entry_o.rd       = dec.rd;
        rob_entry_o.pd       = has_dest ? fl_tag_i : '0;
        rob_entry_o.has_dest = has_dest;

        rs_entry_o.op       = dec.op;
        rs_entry_o.ps1      = ren_rsp_i.ps1;
        rs_entry_o.ps2      = ren_rsp_i.ps2;
        rs_entry_o.rdy1     = ren_rsp_i.rdy1;
        rs_entry_o.rdy2     = ren_rsp_i.rdy2;
        rs_entry_o.pd       = rob_entry_o.pd;
        rs_entry_o.has_dest = has_dest;
        rs_entry_o.imm      = dec.imm;
        rs_entry_o.use_imm  = dec.use_imm;
        rs_entry_o.rob_idx  = rob_idx_i;
    end

endmodule

//--- verilog/rat.sv
module rat
import cpu_params::*;
(
    input  logic              clk,
    input  logic              arst_n_i,
    input  rename_req_t       ren_req_i,
    output rename_rsp_t       ren_rsp_o,
    input  logic [PREG_W-1:0] new_pd_i,
    input  cdb_t              cdb_i
);

    logic [PREG_W-1:0]    map_q [ARCH_REGS];
    logic [PHYS_REGS-1:0] ready_q;

    always_comb begin
        ren_rsp_o.ps1    = map_q[ren_req_i.rs1];
        ren_rsp_o.ps2    = map_q[ren_req_i.rs2];
        ren_rsp_o.rdy1   = ready_q[ren_rsp_o.ps1];
        ren_rsp_o.rdy2   = ready_q[ren_rsp_o.ps2];
        ren_rsp_o.old_pd = map_q[ren_req_i.rd];
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= PREG_W'(i);
            end
            ready_q <= '1;
        end else begin
            if (cdb_i.valid && cdb_i.has_dest) begin
                ready_q[cdb_i.pd] <= 1'b1;
            end
            // The new tag is free, so it never collides with the CDB tag.
            if (ren_req_i.we) begin
                map_q[ren_req_i.rd] <= new_pd_i;
                ready_q[new_pd_i]   <= 1'b0;
            end
        end
    end

    // x0 keeps phys 0 forever.
    a_no_x0_rename: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        ren_req_i.we |-> ren_req_i.rd != '0
    );

endmodule

//--- verilog/free_list.sv
module free_list
import cpu_params::*;
(
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              pop_i,
    output logic [PREG_W-1:0] tag_o,
    output logic              empty_o,
    input  logic              push_i,
    input  logic [PREG_W-1:0] push_tag_i
);

    logic [PREG_W-1:0]   tags_q [FL_DEPTH];
    logic [FL_IDX_W-1:0] head_q;
    logic [FL_IDX_W-1:0] tail_q;
    logic [FL_IDX_W:0]   count_q;

    assign tag_o   = tags_q[head_q];
    assign empty_o = count_q == '0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // Starts full with the tags above the architectural range.
            for (int i = 0; i < FL_DEPTH; i++) begin
                tags_q[i] <= PREG_W'(ARCH_REGS + i);
            end
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= (FL_IDX_W + 1)'(FL_DEPTH);
        end else begin
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
            if (push_i) begin
                tags_q[tail_q] <= push_tag_i;
                tail_q         <= tail_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        pop_i |-> !empty_o
    );

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        push_i |-> count_q != (FL_IDX_W + 1)'(FL_DEPTH)
    );

endmodule

//--- verilog/rob.sv
module rob
import cpu_params::*;
(
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 alloc_i,
    input  rob_alloc_t           alloc_entry_i,
    output logic [ROB_IDX_W-1:0] idx_o,
    output logic                 full_o,
    input  cdb_t                 cdb_i,
    output retire_t              retire_o,
    output logic                 commit_valid_o,
    output commit_t              commit_o
);

    rob_alloc_t           entry_q [ROB_DEPTH];
    logic [XLEN-1:0]      data_q  [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] busy_q;
    logic [ROB_DEPTH-1:0] done_q;
    logic [ROB_IDX_W-1:0] head_q;
    logic [ROB_IDX_W-1:0] tail_q;
    logic [ROB_IDX_W:0]   count_q;
    logic                 retire;

    assign idx_o  = tail_q;
    assign full_o = count_q == (ROB_IDX_W + 1)'(ROB_DEPTH);
    assign retire = busy_q[head_q] & done_q[head_q];

    always_comb begin
        retire_o.valid    = retire;
        retire_o.rd       = entry_q[head_q].rd;
        retire_o.pd       = entry_q[head_q].pd;
        retire_o.has_dest = entry_q[head_q].has_dest;
        commit_valid_o    = retire;
        commit_o.rd       = entry_q[head_q].rd;
        // Writes to x0 commit as zero.
        commit_o.data     = entry_q[head_q].has_dest ? data_q[head_q] : '0;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_i) begin
                busy_q[tail_q] <= 1'b1;
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (cdb_i.valid) begin
                done_q[cdb_i.rob_idx] <= 1'b1;
            end
            if (retire) begin
                busy_q[head_q] <= 1'b0;
                head_q         <= head_q + 1'b1;
            end
            case ({alloc_i, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_i) begin
            entry_q[tail_q] <= alloc_entry_i;
        end
        if (cdb_i.valid) begin
            data_q[cdb_i.rob_idx] <= cdb_i.data;
        end
    end

    // Each entry completes exactly once while it is live.
    a_cdb_live: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        cdb_i.valid |-> busy_q[cdb_i.rob_idx] && !done_q[cdb_i.rob_idx]
    );

endmodule

//--- verilog/int_rs.sv
module int_rs
import cpu_params::*;
(
    input  logic      clk,
    input  logic      arst_n_i,
    input  logic      write_i,
    input  rs_entry_t entry_i,
    output logic      full_o,
    input  cdb_t      cdb_i,
    output logic      issue_valid_o,
    output issue_t    issue_o
);

    rs_entry_t           slot_q [RS_DEPTH];
    logic [RS_DEPTH-1:0] valid_q;
    logic [RS_DEPTH-1:0] rdy1;
    logic [RS_DEPTH-1:0] rdy2;
    logic [RS_DEPTH-1:0] ready;
    logic [RS_IDX_W-1:0] free_idx;
    logic [RS_IDX_W-1:0] issue_idx;
    rs_entry_t           new_entry;
    rs_entry_t           sel;
    logic [RS_DEPTH-1:0] src_pending;

    function automatic logic cdb_hit(cdb_t bus, logic [PREG_W-1:0] tag);
        return bus.valid && bus.has_dest && bus.pd == tag;
    endfunction

    // Wakeup from the CDB counts in the cycle the tag is broadcast.
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            rdy1[i]  = slot_q[i].rdy1 | cdb_hit(cdb_i, slot_q[i].ps1);
            rdy2[i]  = slot_q[i].rdy2 | cdb_hit(cdb_i, slot_q[i].ps2);
            ready[i] = valid_q[i] & rdy1[i] & rdy2[i];
        end
        new_entry      = entry_i;
        new_entry.rdy1 = entry_i.rdy1 | cdb_hit(cdb_i, entry_i.ps1);
        new_entry.rdy2 = entry_i.rdy2 | cdb_hit(cdb_i, entry_i.ps2);
    end

    // Lowest index wins for both allocation and issue.
    always_comb begin
        free_idx  = '0;
        issue_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = RS_IDX_W'(i);
            end
            if (ready[i]) begin
                issue_idx = RS_IDX_W'(i);
            end
        end
    end

    assign full_o        = &valid_q;
    assign issue_valid_o = |ready;
    assign sel           = slot_q[issue_idx];

    always_comb begin
        issue_o.op       = sel.op;
        issue_o.ps1      = sel.ps1;
        issue_o.ps2      = sel.ps2;
        issue_o.pd       = sel.pd;
        issue_o.has_dest = sel.has_dest;
        issue_o.imm      = sel.imm;
        issue_o.use_imm  = sel.use_imm;
        issue_o.rob_idx  = sel.rob_idx;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else begin
            if (write_i) begin
                valid_q[free_idx] <= 1'b1;
            end
            if (issue_valid_o) begin
                valid_q[issue_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            slot_q[i].rdy1 <= rdy1[i];
            slot_q[i].rdy2 <= rdy2[i];
        end
        if (write_i) begin
            slot_q[free_idx] <= new_entry;
        end
    end

    // Slots whose producer tag is a source of the selected entry.
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            src_pending[i] = valid_q[i] && slot_q[i].has_dest &&
                             (slot_q[i].pd == sel.ps1 || slot_q[i].pd == sel.ps2);
        end
    end

    // An operand is only ready once its producer has left the station.
    a_issue_ready: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        issue_valid_o |-> src_pending == '0
    );

endmodule

//--- verilog/int_exec.sv
module int_exec
import cpu_params::*;
(
    input  logic   clk,
    input  logic   arst_n_i,
    input  logic   issue_valid_i,
    input  issue_t issue_i,
    output cdb_t   cdb_o
);

    logic [XLEN-1:0] rf_q [PHYS_REGS];
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] result;
    cdb_t            cdb_q;

    assign op_a = rf_q[issue_i.ps1];
    assign op_b = issue_i.use_imm ? issue_i.imm : rf_q[issue_i.ps2];

    always_comb begin
        case (issue_i.op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            default: result = '0;
        endcase
    end

    // The register file and the CDB update on the same edge.
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                rf_q[i] <= '0;
            end
            cdb_q <= '0;
        end else begin
            cdb_q.valid    <= issue_valid_i;
            cdb_q.pd       <= issue_i.pd;
            cdb_q.has_dest <= issue_i.has_dest;
            cdb_q.rob_idx  <= issue_i.rob_idx;
            cdb_q.data     <= result;
            if (issue_valid_i && issue_i.has_dest) begin
                rf_q[issue_i.pd] <= result;
            end
        end
    end

    assign cdb_o = cdb_q;

endmodule

//--- verilog/rrf.sv
module rrf
import cpu_params::*;
(
    input  logic              clk,
    input  logic              arst_n_i,
    input  retire_t           retire_i,
    output logic              fl_push_o,
    output logic [PREG_W-1:0] fl_tag_o
);

    logic [PREG_W-1:0] map_q [ARCH_REGS];

    // The tag being replaced has no readers left once its successor retires.
    assign fl_push_o = retire_i.valid & retire_i.has_dest;
    assign fl_tag_o  = map_q[retire_i.rd];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= PREG_W'(i);
            end
        end else if (fl_push_o) begin
            map_q[retire_i.rd] <= retire_i.pd;
        end
    end

endmodule

//--- verilog/backend_top.sv
module backend_top
import cpu_params::*;
(
    input  logic        clk,
    input  logic        arst_n_i,
    input  logic        inst_valid_i,
    input  logic [31:0] inst_i,
    output logic        inst_pop_o,
    output logic        commit_valid_o,
    output commit_t     commit_o
);

    rename_req_t          ren_req;
    rename_rsp_t          ren_rsp;
    logic                 fl_pop;
    logic                 fl_empty;
    logic [PREG_W-1:0]    fl_tag;
    logic                 fl_push;
    logic [PREG_W-1:0]    fl_push_tag;
    logic                 rob_alloc;
    rob_alloc_t           rob_entry;
    logic [ROB_IDX_W-1:0] rob_idx;
    logic                 rob_full;
    logic                 rs_write;
    rs_entry_t            rs_entry;
    logic                 rs_full;
    logic                 issue_valid;
    issue_t               issue;
    cdb_t                 cdb;
    retire_t              retire;

    id_stage id_stage_i (
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_pop_o   (inst_pop_o),
        .rob_full_i   (rob_full),
        .rs_full_i    (rs_full),
        .fl_empty_i   (fl_empty),
        .ren_req_o    (ren_req),
        .ren_rsp_i    (ren_rsp),
        .fl_pop_o     (fl_pop),
        .fl_tag_i     (fl_tag),
        .rob_alloc_o  (rob_alloc),
        .rob_entry_o  (rob_entry),
        .rob_idx_i    (rob_idx),
        .rs_write_o   (rs_write),
        .rs_entry_o   (rs_entry)
    );

    rat rat_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .ren_req_i (ren_req),
        .ren_rsp_o (ren_rsp),
        .new_pd_i  (fl_tag),
        .cdb_i     (cdb)
    );

    free_list free_list_i (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .pop_i      (fl_pop),
        .tag_o      (fl_tag),
        .empty_o    (fl_empty),
        .push_i     (fl_push),
        .push_tag_i (fl_push_tag)
    );

    rob rob_i (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .alloc_i        (rob_alloc),
        .alloc_entry_i  (rob_entry),
        .idx_o          (rob_idx),
        .full_o         (rob_full),
        .cdb_i          (cdb),
        .retire_o       (retire),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    int_rs int_rs_i (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .write_i       (rs_write),
        .entry_i       (rs_entry),
        .full_o        (rs_full),
        .cdb_i         (cdb),
        .issue_valid_o (issue_valid),
        .issue_o       (issue)
    );

    int_exec int_exec_i (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .cdb_o         (cdb)
    );

    rrf rrf_i (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .retire_i  (retire),
        .fl_push_o (fl_push),
        .fl_tag_o  (fl_push_tag)
    );

endmodule

//--- test/backend_tb.sv
module backend_tb
import cpu_params::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_T1 = 1;
    localparam int N_T2 = 300;
    localparam int N_T3 = 300;
    localparam int N_T4 = 200;
    localparam int N_T5 = 200;
    localparam int N_T6 = 2000;
    localparam int N_ALL = N_T1 + N_T2 + N_T3 + N_T4 + N_T5 + N_T6;
    localparam int TIMEOUT_CYCLES = 8 * N_ALL + 1000;

    logic        clk;
    logic        arst_n_i;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic        inst_pop_o;
    logic        commit_valid_o;
    commit_t     commit_o;

    integer      seed = 32'hf3ae;
    logic [31:0] arch [32];
    commit_t     exp_q [$];
    int          cycles;
    int          commits;
    int          sup_pops;
    int          stalls;
    int          checks;
    int          errors;
    int          test_num;
    int          last_commits;
    int          last_pops;
    int          last_stalls;
    int          last_errors;

    backend_top dut (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .inst_pop_o     (inst_pop_o),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int rand_range(int lo, int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic logic [4:0] pick_reg(int lo, int hi, int x0_pct);
        logic [4:0] r;
        r = 5'(rand_range(lo, hi));
        if (rand_range(0, 99) < x0_pct) begin
            r = '0;
        end
        return r;
    endfunction

    // Random RV32I word, optionally one the back end must drop.
    function automatic logic [31:0] rand_inst(int lo, int hi, int x0_pct, int bad_pct);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [31:0] junk;
        logic [31:0] w;
        rd   = pick_reg(lo, hi, x0_pct);
        rs1  = pick_reg(lo, hi, x0_pct);
        rs2  = pick_reg(lo, hi, x0_pct);
        imm  = 12'(rand_range(0, 4095));
        junk = $random(seed);
        if (rand_range(0, 99) < bad_pct) begin
            case (rand_range(0, 2))
                0:       w = {junk[31:7], 7'b1100011};
                1:       w = {7'b0000000, rs2, rs1, 3'b001, rd, 7'b0110011};
                default: w = {imm, rs1, 3'b010, rd, 7'b0010011};
            endcase
        end else begin
            case (rand_range(0, 8))
                0:       w = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
                1:       w = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
                2:       w = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
                3:       w = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
                4:       w = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
                5:       w = {imm, rs1, 3'b000, rd, 7'b0010011};
                6:       w = {imm, rs1, 3'b111, rd, 7'b0010011};
                7:       w = {imm, rs1, 3'b110, rd, 7'b0010011};
                default: w = {imm, rs1, 3'b100, rd, 7'b0010011};
            endcase
        end
        return w;
    endfunction

    // In-order ISA model of one popped word.
    task automatic model_exec(input logic [31:0] w);
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] res;
        logic        ok;
        commit_t     exp;
        rd  = w[11:7];
        a   = arch[w[19:15]];
        b   = arch[w[24:20]];
        imm = {{20{w[31]}}, w[31:20]};
        ok  = 1'b1;
        res = '0;
        if (w[6:0] == 7'b0110011) begin
            case ({w[31:25], w[14:12]})
                10'b0000000_000: res = a + b;
                10'b0100000_000: res = a - b;
                10'b0000000_111: res = a & b;
                10'b0000000_110: res = a | b;
                10'b0000000_100: res = a ^ b;
                default:         ok = 1'b0;
            endcase
        end else if (w[6:0] == 7'b0010011) begin
            case (w[14:12])
                3'b000:  res = a + imm;
                3'b111:  res = a & imm;
                3'b110:  res = a | imm;
                3'b100:  res = a ^ imm;
                default: ok = 1'b0;
            endcase
        end else begin
            ok = 1'b0;
        end
        if (ok) begin
            if (rd != '0) begin
                arch[rd] = res;
            end
            exp.rd   = rd;
            exp.data = (rd == '0) ? '0 : res;
            exp_q.push_back(exp);
            sup_pops++;
        end
    endtask

    task automatic check_commit();
        commit_t exp;
        commits++;
        checks++;
        assert (exp_q.size() > 0) else begin
            $display("Commit of x%0d at %0t ns with no instruction outstanding", commit_o.rd, $time);
            errors++;
        end
        if (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            assert (commit_o.rd == exp.rd) else begin
                $display("Fail at %0t ns: commit_o.rd = %0d, expected %0d",
                         $time, commit_o.rd, exp.rd);
                errors++;
            end
            assert (commit_o.data == exp.data) else begin
                $display("Fail at %0t ns: commit_o.data = 0x%08h, expected 0x%08h",
                         $time, commit_o.data, exp.data);
                errors++;
            end
        end
    endtask

    // Outputs are read at the rising edge, before any flop moves.
    always @(posedge clk) begin
        if (arst_n_i) begin
            cycles++;
            assert (!inst_pop_o || inst_valid_i) else begin
                $display("inst_pop_o went high at %0t ns while inst_valid_i was low", $time);
                errors++;
            end
            if (inst_valid_i && !inst_pop_o) begin
                stalls++;
            end
            if (inst_valid_i && inst_pop_o) begin
                model_exec(inst_i);
            end
            if (commit_valid_o) begin
                check_commit();
            end
        end
    end

    // Called on a falling edge; returns on a falling edge.
    task automatic send_inst(input logic [31:0] w, input int max_gap);
        int gap;
        gap          = (max_gap > 0) ? rand_range(0, max_gap) : 0;
        inst_valid_i = 1'b1;
        inst_i       = w;
        @(posedge clk);
        while (!inst_pop_o) begin
            @(posedge clk);
        end
        @(negedge clk);
        if (gap > 0) begin
            inst_valid_i = 1'b0;
            inst_i       = $random(seed);
            repeat (gap) @(negedge clk);
        end
    endtask

    task automatic run_random(int n, int lo, int hi, int x0_pct, int bad_pct, int max_gap);
        for (int i = 0; i < n; i++) begin
            send_inst(rand_inst(lo, hi, x0_pct, bad_pct), max_gap);
        end
    endtask

    task automatic end_test(input string name);
        inst_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        checks++;
        assert (commits - last_commits == sup_pops - last_pops) else begin
            $display("Test %s committed %0d instructions but %0d supported ones were popped",
                     name, commits - last_commits, sup_pops - last_pops);
            errors++;
        end
        test_num++;
        $display("Test %0d %-14s %5d commits, %4d pop stalls, %0d errors", test_num, name,
                 commits - last_commits, stalls - last_stalls, errors - last_errors);
        last_commits = commits;
        last_pops    = sup_pops;
        last_stalls  = stalls;
        last_errors  = errors;
    endtask

    initial begin
        wait (cycles >= TIMEOUT_CYCLES);
        $display("Timeout after %0d cycles with %0d commits still outstanding",
                 cycles, exp_q.size());
        $display("Simulation failed");
        $finish;
    end

    initial begin
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        for (int i = 0; i < 32; i++) begin
            arch[i] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        // Idle back end, then one ADDI x5, x0, -1595.
        repeat (20) begin
            @(negedge clk);
            checks++;
            assert (!commit_valid_o) else begin
                $display("Fail at %0t ns: commit_valid_o = 1, expected 0", $time);
                errors++;
            end
        end
        send_inst({12'h9c5, 5'd0, 3'b000, 5'd5, 7'b0010011}, 0);
        end_test("reset_addi");

        run_random(N_T2, 1, 31, 0, 0, 3);
        end_test("independent");
        run_random(N_T3, 1, 4, 0, 0, 2);
        end_test("dep_chains");
        run_random(N_T4, 1, 3, 0, 0, 0);
        end_test("backpressure");
        run_random(N_T5, 1, 8, 25, 20, 2);
        end_test("x0_unsupported");
        run_random(N_T6, 1, 31, 5, 5, 1);
        end_test("long_mixed");

        // Any stray commit after the last drain shows up here.
        repeat (20) @(negedge clk);
        $display("%0d tests, %0d commits, %0d checks, %0d errors",
                 test_num, commits, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- files.f
verilog/cpu_params.sv
verilog/id_stage.sv
verilog/rat.sv
verilog/free_list.sv
verilog/rob.sv
verilog/int_rs.sv
verilog/int_exec.sv
verilog/rrf.sv
verilog/backend_top.sv
test/backend_tb.sv

//--- Bender.yml
package:
  name: backend

sources:
  - verilog/cpu_params.sv
  - verilog/id_stage.sv
  - verilog/rat.sv
  - verilog/free_list.sv
  - verilog/rob.sv
  - verilog/int_rs.sv
  - verilog/int_exec.sv
  - verilog/rrf.sv
  - verilog/backend_top.sv
  - target: test
    files:
      - test/backend_tb.sv
